// File: design/apu_regs_pkg.sv
package apu_regs_pkg;

	// Channel 2 register select, page offsets 16 to 19
	typedef enum logic [1:0] {
		NR21 = 2'd0,
		NR22 = 2'd1,
		NR23 = 2'd2,
		NR24 = 2'd3
	} reg_sel_t;

	// Strobes are single cycle
	typedef struct packed {
		logic wr;
		logic rd;
		reg_sel_t sel;
		logic [7:0] wdata;
	} apu_bus_t;

	typedef struct packed {
		logic [1:0] duty;
		logic [5:0] length_load;
	} nr21_t;

	typedef struct packed {
		logic [3:0] init_vol;
		logic env_up;
		logic [2:0] env_period;
	} nr22_t;

	typedef struct packed {
		logic trigger;
		logic length_en;
		logic [2:0] unused;
		logic [2:0] freq_hi;
	} nr24_t;

	// Write-only bits read back as ones
	localparam logic [7:0] READ_MASK_NR21 = 8'h3F;
	localparam logic [7:0] READ_MASK_NR22 = 8'h00;
	localparam logic [7:0] READ_MASK_NR23 = 8'hFF;
	localparam logic [7:0] READ_MASK_NR24 = 8'hBF;

endpackage

// File: design/ch2_pkg.sv
package ch2_pkg;

	localparam int CTRL_FREQ_W = 11;
	localparam int CTRL_LEN_W = 6;

	// Waveform duty, 12.5 to 75 percent
	typedef enum logic [1:0] {
		D12 = 2'd0,
		D25 = 2'd1,
		D50 = 2'd2,
		D75 = 2'd3
	} duty_t;

	// Decoded register contents for the generators
	typedef struct packed {
		duty_t duty;
		logic [CTRL_FREQ_W-1:0] freq;
		logic [CTRL_LEN_W-1:0] length_load;
		logic length_en;
		logic [3:0] env_init;
		logic env_up;
		logic [2:0] env_period;
		logic dac_on;
	} ch2_ctrl_t;

endpackage

// File: design/ch2_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ch2_regs
	import apu_regs_pkg::*, ch2_pkg::*;
#(
	parameter int FREQ_BITS = 11,
	parameter int LENGTH_BITS = 6
) (
	input logic clk,
	input logic reset,
	input apu_bus_t bus,
	output logic [7:0] rdata,
	output logic rd_valid,
	output ch2_ctrl_t ctrl,
	output logic trigger,
	output logic length_load
);

	nr21_t nr21_q;
	nr22_t nr22_q;
	logic [7:0] nr23_q;
	nr24_t nr24_q;
	nr24_t nr24_wr;
	logic [FREQ_BITS-1:0] freq;
	logic [LENGTH_BITS-1:0] len_load;

	assign nr24_wr = nr24_t'(bus.wdata);

	// Write capture, trigger and length load pulses
	always_ff @(posedge clk) begin
		if (reset) begin
			nr21_q <= '0;
			nr22_q <= '0;
			nr23_q <= '0;
			nr24_q <= '0;
			trigger <= 1'b0;
			length_load <= 1'b0;
		end else begin
			trigger <= 1'b0;
			length_load <= 1'b0;
			if (bus.wr) begin
				case (bus.sel)
					NR21: begin
						nr21_q <= nr21_t'(bus.wdata);
						length_load <= 1'b1;
					end
					NR22: begin
						nr22_q <= nr22_t'(bus.wdata);
					end
					NR23: begin
						nr23_q <= bus.wdata;
					end
					NR24: begin
						nr24_q <= nr24_wr;
						// Trigger bit is a strobe only
						nr24_q.trigger <= 1'b0;
						trigger <= nr24_wr.trigger;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= bus.rd;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.rd) begin
			case (bus.sel)
				NR21: rdata <= nr21_q | READ_MASK_NR21;
				NR22: rdata <= nr22_q | READ_MASK_NR22;
				NR23: rdata <= nr23_q | READ_MASK_NR23;
				NR24: rdata <= nr24_q | READ_MASK_NR24;
			endcase
		end
	end

	assign freq = FREQ_BITS'({nr24_q.freq_hi, nr23_q});
	assign len_load = LENGTH_BITS'(nr21_q.length_load);

	always_comb begin
		ctrl.duty = duty_t'(nr21_q.duty);
		ctrl.freq = CTRL_FREQ_W'(freq);
		ctrl.length_load = CTRL_LEN_W'(len_load);
		ctrl.length_en = nr24_q.length_en;
		ctrl.env_init = nr22_q.init_vol;
		ctrl.env_up = nr22_q.env_up;
		ctrl.env_period = nr22_q.env_period;
		// DAC powered while volume or direction bits are set
		ctrl.dac_on = |{nr22_q.init_vol, nr22_q.env_up};
	end

	// One rd_valid pulse per single-cycle read strobe
	a_rd_valid_follows_rd: assert property (
		@(posedge clk) disable iff (reset)
		bus.rd |=> rd_valid && !bus.rd
	);

endmodule

`default_nettype wire

// File: design/ch2_freq_timer.sv
`timescale 1ns/1ns
`default_nettype none

module ch2_freq_timer
	import ch2_pkg::*;
#(
	parameter int FREQ_BITS = 11
) (
	input logic clk,
	input logic reset,
	input logic timer_tick,
	input logic trigger,
	input logic [FREQ_BITS-1:0] freq,
	input duty_t duty,
	output logic wave_bit
);

	// Holds ticks left in the step minus one
	logic [FREQ_BITS-1:0] count;
	logic [FREQ_BITS-1:0] reload;
	logic [2:0] step;
	logic [7:0] pattern;

	// 2^FREQ_BITS - freq - 1
	assign reload = ~freq;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			step <= '0;
		end else if (trigger) begin
			count <= reload;
			step <= '0;
		end else if (timer_tick) begin
			if (count == '0) begin
				count <= reload;
				step <= step + 3'd1;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// One bit per step, step 7 is the msb
	always_comb begin
		unique case (duty)
			D12: pattern = 8'b1000_0000;
			D25: pattern = 8'b1000_0001;
			D50: pattern = 8'b1110_0001;
			D75: pattern = 8'b0111_1110;
		endcase
	end

	assign wave_bit = pattern[step];

	a_step_on_tick: assert property (
		@(posedge clk) disable iff (reset)
		$changed(step) |-> $past(timer_tick || trigger)
	);

endmodule

`default_nettype wire

// File: design/ch2_length.sv
`timescale 1ns/1ns
`default_nettype none

module ch2_length #(
	parameter int LENGTH_BITS = 6
) (
	input logic clk,
	input logic reset,
	input logic len_tick,
	input logic length_en,
	input logic [LENGTH_BITS-1:0] length_load_val,
	input logic length_load,
	input logic trigger,
	output logic length_expired
);

	logic [LENGTH_BITS-1:0] count;

	// Counts up from the load value, expires on wrap
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			length_expired <= 1'b1;
		end else if (length_load) begin
			count <= length_load_val;
			length_expired <= 1'b0;
		end else if (trigger && length_expired) begin
			// Re-arm with a full length
			count <= '0;
			length_expired <= 1'b0;
		end else if (len_tick && length_en && !length_expired) begin
			count <= count + 1'b1;
			if (&count) begin
				length_expired <= 1'b1;
			end
		end
	end

	a_expire_on_tick: assert property (
		@(posedge clk) disable iff (reset)
		$rose(length_expired) |-> $past(len_tick)
	);

endmodule

`default_nettype wire

// File: design/ch2_envelope.sv
`timescale 1ns/1ns
`default_nettype none

module ch2_envelope (
	input logic clk,
	input logic reset,
	input logic env_tick,
	input logic trigger,
	input logic [3:0] env_init,
	input logic env_up,
	input logic [2:0] env_period,
	output logic [3:0] volume
);

	logic [2:0] period_cnt;
	logic [2:0] next_cnt;

	assign next_cnt = period_cnt + 3'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			period_cnt <= '0;
			volume <= '0;
		end else if (trigger) begin
			period_cnt <= '0;
			volume <= env_init;
		end else if (env_tick && env_period != 3'd0) begin
			if (next_cnt == env_period) begin
				period_cnt <= '0;
				// Saturate at either end
				if (env_up && volume != 4'd15) begin
					volume <= volume + 4'd1;
				end else if (!env_up && volume != 4'd0) begin
					volume <= volume - 4'd1;
				end
			end else begin
				period_cnt <= next_cnt;
			end
		end
	end

	a_volume_on_tick: assert property (
		@(posedge clk) disable iff (reset)
		$changed(volume) |-> $past(env_tick || trigger)
	);

endmodule

`default_nettype wire

// File: design/ch2_top.sv
`timescale 1ns/1ns
`default_nettype none

module ch2_top
	import apu_regs_pkg::*, ch2_pkg::*;
#(
	parameter int FREQ_BITS = 11,
	parameter int LENGTH_BITS = 6
) (
	input logic clk,
	input logic reset,
	input apu_bus_t bus,
	input logic timer_tick,
	input logic len_tick,
	input logic env_tick,
	output logic [7:0] rdata,
	output logic rd_valid,
	output logic [3:0] sample,
	output logic active
);

	ch2_ctrl_t ctrl;
	logic trigger;
	logic length_load;
	logic length_expired;
	logic len_expired_q;
	logic expired_rise;
	logic wave_bit;
	logic [3:0] volume;

	ch2_regs #(
		.FREQ_BITS(FREQ_BITS),
		.LENGTH_BITS(LENGTH_BITS)
	) regs (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.rdata(rdata),
		.rd_valid(rd_valid),
		.ctrl(ctrl),
		.trigger(trigger),
		.length_load(length_load)
	);

	ch2_freq_timer #(
		.FREQ_BITS(FREQ_BITS)
	) freq_timer (
		.clk(clk),
		.reset(reset),
		.timer_tick(timer_tick),
		.trigger(trigger),
		.freq(FREQ_BITS'(ctrl.freq)),
		.duty(ctrl.duty),
		.wave_bit(wave_bit)
	);

	ch2_length #(
		.LENGTH_BITS(LENGTH_BITS)
	) length (
		.clk(clk),
		.reset(reset),
		.len_tick(len_tick),
		.length_en(ctrl.length_en),
		.length_load_val(LENGTH_BITS'(ctrl.length_load)),
		.length_load(length_load),
		.trigger(trigger),
		.length_expired(length_expired)
	);

	ch2_envelope envelope (
		.clk(clk),
		.reset(reset),
		.env_tick(env_tick),
		.trigger(trigger),
		.env_init(ctrl.env_init),
		.env_up(ctrl.env_up),
		.env_period(ctrl.env_period),
		.volume(volume)
	);

	assign expired_rise = length_expired && !len_expired_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			len_expired_q <= 1'b1;
			active <= 1'b0;
			sample <= '0;
		end else begin
			len_expired_q <= length_expired;
			// DAC off wins over everything
			if (!ctrl.dac_on) begin
				active <= 1'b0;
			end else if (trigger) begin
				active <= 1'b1;
			end else if (expired_rise) begin
				active <= 1'b0;
			end
			sample <= (active && wave_bit) ? volume : 4'd0;
		end
	end

endmodule

`default_nettype wire

// File: testbench/ch2_tb_tasks.svh
`ifndef CH2_TB_TASKS_SVH
`define CH2_TB_TASKS_SVH

// Readback OR masks, write-only bits read as ones
function automatic logic [7:0] read_mask(input reg_sel_t sel);
	case (sel)
		NR21: return 8'h3F;
		NR22: return 8'h00;
		NR23: return 8'hFF;
		default: return 8'hBF;
	endcase
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("ERROR: time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
			expected);
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first mismatch");
	end
endtask

task automatic fail_timeout(input string what);
	$display("Timed out: %s", what);
	$display("=== FAIL ===");
	$fatal(1, "Stopped on a timeout");
endtask

// Outputs are sampled on the falling edge
task automatic settle(input int cycles);
	repeat (cycles) @(posedge clk);
	@(negedge clk);
endtask

task automatic write_reg(input reg_sel_t sel, input logic [7:0] data);
	@(posedge clk);
	bus <= '{wr: 1'b1, rd: 1'b0, sel: sel, wdata: data};
	@(posedge clk);
	bus <= '0;
endtask

task automatic read_reg(input reg_sel_t sel, output logic [7:0] data);
	int waited;
	@(posedge clk);
	bus <= '{wr: 1'b0, rd: 1'b1, sel: sel, wdata: 8'h00};
	@(posedge clk);
	bus <= '0;
	waited = 1;
	@(negedge clk);
	while (!rd_valid) begin
		if (waited >= 4) begin
			fail_timeout("no read data came back after a read strobe");
		end
		waited++;
		@(negedge clk);
	end
	check_value("rd_valid latency", waited, 1);
	data = rdata;
	@(negedge clk);
	check_value("rd_valid", rd_valid, 0);
endtask

task automatic send_tick(input bit to_envelope);
	@(posedge clk);
	if (to_envelope) begin
		env_tick <= 1'b1;
	end else begin
		len_tick <= 1'b1;
	end
	@(posedge clk);
	env_tick <= 1'b0;
	len_tick <= 1'b0;
endtask

task automatic wait_inactive(input int limit, input string what);
	int waited;
	waited = 0;
	@(negedge clk);
	while (active) begin
		waited++;
		if (waited > limit) begin
			fail_timeout(what);
		end
		@(negedge clk);
	end
endtask

`endif

// File: testbench/ch2_tb.sv
`timescale 1ns/1ns

module ch2_tb
	import apu_regs_pkg::*;
();

	typedef enum logic [2:0] {K_RDBK, K_ENV, K_FREQ, K_LEN, K_DAC} kind_t;

	// Register values, tick count and expected result of one case
	typedef struct packed {
		kind_t kind;
		logic [7:0] nr21;
		logic [7:0] nr22;
		logic [7:0] nr23;
		logic [7:0] nr24;
		logic [7:0] nr22_off;
		logic [15:0] ticks;
		logic [15:0] expected;
	} stim_t;

	localparam int NUM_CASES = 10;

	logic clk;
	logic reset;
	apu_bus_t bus;
	logic timer_tick;
	logic len_tick;
	logic env_tick;
	logic [7:0] rdata;
	logic rd_valid;
	logic [3:0] sample;
	logic active;
	stim_t stim [NUM_CASES];
	integer seed;

	ch2_top #(
		.FREQ_BITS(11),
		.LENGTH_BITS(6)
	) UUT (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.timer_tick(timer_tick),
		.len_tick(len_tick),
		.env_tick(env_tick),
		.rdata(rdata),
		.rd_valid(rd_valid),
		.sample(sample),
		.active(active)
	);

	always #10 clk = ~clk;

	`include "ch2_tb_tasks.svh"

	task automatic load_stim();
		stim[0] = '{K_RDBK, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 16'd12, 16'd0};
		// Envelope up, down and frozen
		stim[1] = '{K_ENV, 8'h80, 8'h5A, 8'h00, 8'h80, 8'h00, 16'd24, 16'd15};
		stim[2] = '{K_ENV, 8'h80, 8'hC3, 8'h00, 8'h80, 8'h00, 16'd45, 16'd0};
		stim[3] = '{K_ENV, 8'h80, 8'h90, 8'h00, 8'h80, 8'h00, 16'd10, 16'd9};
		// Expected is the step length in ticks
		stim[4] = '{K_FREQ, 8'h00, 8'hF0, 8'hF8, 8'h87, 8'h00, 16'd0, 16'd8};
		stim[5] = '{K_FREQ, 8'h00, 8'hF0, 8'hD0, 8'h87, 8'h00, 16'd0, 16'd48};
		// Expected is the len_tick that ends the channel, 0 for never
		stim[6] = '{K_LEN, 8'hBC, 8'hF0, 8'h00, 8'hC0, 8'h00, 16'd4, 16'd4};
		stim[7] = '{K_LEN, 8'hB0, 8'hF0, 8'h00, 8'hC0, 8'h00, 16'd16, 16'd16};
		stim[8] = '{K_LEN, 8'hBC, 8'hF0, 8'h00, 8'h80, 8'h00, 16'd70, 16'd0};
		stim[9] = '{K_DAC, 8'h80, 8'hA0, 8'h00, 8'h80, 8'h07, 16'd0, 16'd0};
	endtask

	task automatic apply_regs(input stim_t e);
		write_reg(NR21, e.nr21);
		write_reg(NR22, e.nr22);
		write_reg(NR23, e.nr23);
		write_reg(NR24, e.nr24);
	endtask

	task automatic run_readback(input stim_t e);
		logic [31:0] rnd;
		reg_sel_t sel;
		logic [7:0] got;
		for (int r = 0; r < e.ticks; r++) begin
			rnd = $random(seed);
			sel = reg_sel_t'(rnd[1:0]);
			write_reg(sel, rnd[15:8]);
			read_reg(sel, got);
			check_value("rdata", got, rnd[15:8] | read_mask(sel));
		end
	endtask

	task automatic run_envelope(input stim_t e);
		logic [3:0] vol;
		vol = e.nr22[7:4];
		apply_regs(e);
		settle(2);
		check_value("sample", sample, vol);
		for (int t = 1; t <= e.ticks; t++) begin
			send_tick(1'b1);
			settle(1);
			// One step per env_period ticks, clamped at 0 and 15
			if (e.nr22[2:0] != 3'd0 && t % e.nr22[2:0] == 0) begin
				if (e.nr22[3] && vol != 4'd15) begin
					vol = vol + 4'd1;
				end else if (!e.nr22[3] && vol != 4'd0) begin
					vol = vol - 4'd1;
				end
			end
			check_value("sample", sample, vol);
		end
		check_value("final volume", vol, e.expected);
	endtask

	task automatic run_freq(input stim_t e);
		int step_len;
		int high;
		int run;
		int longest;
		step_len = 2048 - {e.nr24[2:0], e.nr23};
		check_value("step length", step_len, e.expected);
		@(posedge clk);
		timer_tick <= 1'b1;
		apply_regs(e);
		settle(2);
		high = 0;
		run = 0;
		longest = 0;
		// Two full periods of eight steps, D12 is high in one
		repeat (16 * step_len) begin
			@(negedge clk);
			if (sample != 4'd0) begin
				check_value("sample", sample, e.nr22[7:4]);
				high++;
				run++;
				if (run > longest) begin
					longest = run;
				end
			end else begin
				run = 0;
			end
		end
		check_value("high cycles", high, 2 * step_len);
		check_value("high run", longest, step_len);
		@(posedge clk);
		timer_tick <= 1'b0;
	endtask

	task automatic run_length(input stim_t e);
		int fall;
		fall = e.nr24[6] ? 64 - e.nr21[5:0] : 0;
		check_value("fall tick", fall, e.expected);
		apply_regs(e);
		settle(2);
		check_value("active", active, 1);
		for (int t = 1; t <= e.ticks; t++) begin
			send_tick(1'b0);
			if (t == fall) begin
				wait_inactive(3, "active did not fall when the length ran out");
			end else begin
				settle(1);
				check_value("active", active, 1);
			end
		end
	endtask

	task automatic run_dac_off(input stim_t e);
		apply_regs(e);
		settle(2);
		check_value("active", active, 1);
		write_reg(NR22, e.nr22_off);
		wait_inactive(2, "active stayed high after the DAC was switched off");
		write_reg(NR24, e.nr24);
		settle(3);
		check_value("active", active, 0);
		check_value("sample", sample, 0);
	endtask

	initial begin
		logic [7:0] got;
		clk = 1'b0;
		reset = 1'b1;
		bus = '0;
		timer_tick = 1'b0;
		len_tick = 1'b0;
		env_tick = 1'b0;
		seed = 32'hd501;
		load_stim();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		settle(0);
		check_value("active", active, 0);
		check_value("sample", sample, 0);
		check_value("rd_valid", rd_valid, 0);
		for (int i = 0; i < 4; i++) begin
			read_reg(reg_sel_t'(i), got);
			check_value("rdata", got, read_mask(reg_sel_t'(i)));
		end
		for (int i = 0; i < NUM_CASES; i++) begin
			case (stim[i].kind)
				K_RDBK: run_readback(stim[i]);
				K_ENV: run_envelope(stim[i]);
				K_FREQ: run_freq(stim[i]);
				K_LEN: run_length(stim[i]);
				default: run_dac_off(stim[i]);
			endcase
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+testbench
design/apu_regs_pkg.sv
design/ch2_pkg.sv
design/ch2_regs.sv
design/ch2_freq_timer.sv
design/ch2_length.sv
design/ch2_envelope.sv
design/ch2_top.sv
testbench/ch2_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the channel 2 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module ch2_tb -Mdir obj_dir -o ch2_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/ch2_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
